/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_axi_isolate
FILELIST := src.f
OBJDIR   := obj_dir
PASS_MSG := No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# Pass only when the testbench prints the pass message on a line of its own
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* src.f */
+incdir+src
src/axi_iso_pkg.sv
src/axi_fwd_reg.sv
src/iso_path_fsm.sv
src/iso_req_tracker.sv
src/iso_wdata_align.sv
src/axi_lite_isolate_mgr.sv
tests/tb_axi_isolate.sv

/* src/axi_fwd_reg.sv */
// One-entry forward register slice; one cycle of latency, full rate only while pop_ready stays high
`timescale 1ns/1ps

module axi_fwd_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_valid,
  input  payload_t push_data,
  output logic     push_ready,
  output logic     pop_valid,
  output payload_t pop_data,
  input  logic     pop_ready
);

  // Room when empty or when the held entry leaves this cycle
  assign push_ready = !pop_valid || pop_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pop_valid <= 1'b0;
    end else if (push_ready) begin
      pop_valid <= push_valid;
    end
  end

  // Payload register, only meaningful while pop_valid is high
  always_ff @(posedge clk) begin
    if (push_valid && push_ready) begin
      pop_data <= push_data;
    end
  end

  // A stalled entry keeps its valid and payload until taken
  pop_hold_a: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

endmodule

/* src/axi_iso_consts.svh */
// AXI-Lite isolator limits; MAX_OUTSTANDING must be at least 2 and fake write beats carry the fill values
`ifndef AXI_ISO_CONSTS_SVH
`define AXI_ISO_CONSTS_SVH

// Bus widths, data must be a whole number of bytes
`define AXI_ISO_ADDR_WIDTH 12
`define AXI_ISO_DATA_WIDTH 32

// Requests per path that may be outstanding before upstream sees back-pressure
`define AXI_ISO_MAX_OUTSTANDING 8

// AW handshakes allowed to run ahead of W
`define AXI_ISO_MAX_SKEW 2

// Payload of the fake W beats issued while aligning
`define AXI_ISO_FILL_WDATA {`AXI_ISO_DATA_WIDTH{1'b0}}
`define AXI_ISO_FILL_WSTRB {(`AXI_ISO_DATA_WIDTH / 8){1'b0}}

`endif

/* src/axi_iso_pkg.sv */
// Types for the AXI-Lite isolator; widths follow axi_iso_consts.svh, no ID, user or burst fields
`include "axi_iso_consts.svh"

package axi_iso_pkg;

  typedef logic [`AXI_ISO_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_ISO_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_ISO_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [2:0] prot_t;
  typedef logic [1:0] resp_t;

  // Counters hold zero up to their limit inclusive
  typedef logic [$clog2(`AXI_ISO_MAX_OUTSTANDING + 1)-1:0] outst_cnt_t;
  typedef logic [$clog2(`AXI_ISO_MAX_SKEW + 1)-1:0] skew_cnt_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_req_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_beat_t;

  typedef struct packed {
    resp_t resp;
  } b_rsp_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_rsp_t;

  // Per-path isolation sequence
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ALIGN,
    ST_DRAIN,
    ST_DONE
  } iso_state_e;

endpackage

/* src/axi_lite_isolate_mgr.sv */
// AXI-Lite manager isolator; hold isolate_req until isolate_done, no bursts, IDs or user fields
`timescale 1ns/1ps
`include "axi_iso_consts.svh"

module axi_lite_isolate_mgr (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  isolate_req,
  output logic                  isolate_done,
  // Upstream manager side
  input  axi_iso_pkg::aw_req_t  up_aw,
  input  logic                  up_aw_valid,
  output logic                  up_aw_ready,
  input  axi_iso_pkg::w_beat_t  up_w,
  input  logic                  up_w_valid,
  output logic                  up_w_ready,
  output axi_iso_pkg::b_rsp_t   up_b,
  output logic                  up_b_valid,
  input  logic                  up_b_ready,
  input  axi_iso_pkg::ar_req_t  up_ar,
  input  logic                  up_ar_valid,
  output logic                  up_ar_ready,
  output axi_iso_pkg::r_rsp_t   up_r,
  output logic                  up_r_valid,
  input  logic                  up_r_ready,
  // Downstream subordinate side
  output axi_iso_pkg::aw_req_t  dn_aw,
  output logic                  dn_aw_valid,
  input  logic                  dn_aw_ready,
  output axi_iso_pkg::w_beat_t  dn_w,
  output logic                  dn_w_valid,
  input  logic                  dn_w_ready,
  input  axi_iso_pkg::b_rsp_t   dn_b,
  input  logic                  dn_b_valid,
  output logic                  dn_b_ready,
  output axi_iso_pkg::ar_req_t  dn_ar,
  output logic                  dn_ar_valid,
  input  logic                  dn_ar_ready,
  input  axi_iso_pkg::r_rsp_t   dn_r,
  input  logic                  dn_r_valid,
  output logic                  dn_r_ready
);

  import axi_iso_pkg::*;

  logic    align_req_w;
  logic    align_done_w;
  logic    drain_req_w;
  logic    drain_done_w;
  logic    path_done_w;
  logic    aw_align_valid;
  logic    aw_trk_ready;
  logic    aw_slice_valid;
  logic    aw_slice_ready;
  logic    w_slice_valid;
  logic    w_slice_ready;
  w_beat_t w_fill;
  w_beat_t w_push;

  logic    align_req_r;
  logic    drain_req_r;
  logic    drain_done_r;
  logic    path_done_r;
  logic    ar_gate_valid;
  logic    ar_trk_ready;
  logic    ar_slice_valid;
  logic    ar_slice_ready;

  // Write path
  iso_path_fsm u_fsm_w (
    .clk         (clk),
    .rst         (rst),
    .isolate_req (isolate_req),
    .align_done  (align_done_w),
    .drain_done  (drain_done_w),
    .align_req   (align_req_w),
    .drain_req   (drain_req_w),
    .path_done   (path_done_w)
  );

  iso_wdata_align u_align_w (
    .clk         (clk),
    .rst         (rst),
    .align_req   (align_req_w),
    .up_aw_valid (up_aw_valid),
    .up_aw_ready (up_aw_ready),
    .up_w_valid  (up_w_valid),
    .up_w_ready  (up_w_ready),
    .dn_aw_valid (aw_align_valid),
    .dn_aw_ready (aw_trk_ready),
    .dn_w_valid  (w_slice_valid),
    .dn_w_ready  (w_slice_ready),
    .align_done  (align_done_w)
  );

  iso_req_tracker u_trk_w (
    .clk         (clk),
    .rst         (rst),
    .drain_req   (drain_req_w),
    .up_ax_valid (aw_align_valid),
    .up_ax_ready (aw_trk_ready),
    .dn_ax_valid (aw_slice_valid),
    .dn_ax_ready (aw_slice_ready),
    .dn_x_valid  (dn_b_valid),
    .dn_x_ready  (dn_b_ready),
    .up_x_valid  (up_b_valid),
    .up_x_ready  (up_b_ready),
    .drain_done  (drain_done_w)
  );

  // Fake beats replace upstream data for the whole write isolation
  assign w_fill = '{data: data_t'(`AXI_ISO_FILL_WDATA), strb: strb_t'(`AXI_ISO_FILL_WSTRB)};
  assign w_push = align_req_w ? w_fill : up_w;
  assign up_b   = dn_b;

  // Read path, a single request channel so alignment is immediate
  iso_path_fsm u_fsm_r (
    .clk         (clk),
    .rst         (rst),
    .isolate_req (isolate_req),
    .align_done  (align_req_r),
    .drain_done  (drain_done_r),
    .align_req   (align_req_r),
    .drain_req   (drain_req_r),
    .path_done   (path_done_r)
  );

  assign ar_gate_valid = up_ar_valid && !align_req_r;
  assign up_ar_ready   = ar_trk_ready && !align_req_r;

  iso_req_tracker u_trk_r (
    .clk         (clk),
    .rst         (rst),
    .drain_req   (drain_req_r),
    .up_ax_valid (ar_gate_valid),
    .up_ax_ready (ar_trk_ready),
    .dn_ax_valid (ar_slice_valid),
    .dn_ax_ready (ar_slice_ready),
    .dn_x_valid  (dn_r_valid),
    .dn_x_ready  (dn_r_ready),
    .up_x_valid  (up_r_valid),
    .up_x_ready  (up_r_ready),
    .drain_done  (drain_done_r)
  );

  assign up_r = dn_r;

  // Rises with both paths done, falls once both have released
  always_ff @(posedge clk) begin
    if (rst) begin
      isolate_done <= 1'b0;
    end else if (isolate_done) begin
      isolate_done <= path_done_w || path_done_r;
    end else begin
      isolate_done <= path_done_w && path_done_r;
    end
  end

  // Output slices keep downstream valids stable when upstream is cut off
  axi_fwd_reg #(.payload_t(aw_req_t)) u_reg_aw (
    .clk        (clk),
    .rst        (rst),
    .push_valid (aw_slice_valid),
    .push_data  (up_aw),
    .push_ready (aw_slice_ready),
    .pop_valid  (dn_aw_valid),
    .pop_data   (dn_aw),
    .pop_ready  (dn_aw_ready)
  );

  axi_fwd_reg #(.payload_t(w_beat_t)) u_reg_w (
    .clk        (clk),
    .rst        (rst),
    .push_valid (w_slice_valid),
    .push_data  (w_push),
    .push_ready (w_slice_ready),
    .pop_valid  (dn_w_valid),
    .pop_data   (dn_w),
    .pop_ready  (dn_w_ready)
  );

  axi_fwd_reg #(.payload_t(ar_req_t)) u_reg_ar (
    .clk        (clk),
    .rst        (rst),
    .push_valid (ar_slice_valid),
    .push_data  (up_ar),
    .push_ready (ar_slice_ready),
    .pop_valid  (dn_ar_valid),
    .pop_data   (dn_ar),
    .pop_ready  (dn_ar_ready)
  );

  // An isolated path accepts nothing from the manager
  no_aw_when_iso_a: assert property (@(posedge clk) disable iff (rst)
    path_done_w |-> !up_aw_ready);
  no_w_when_iso_a: assert property (@(posedge clk) disable iff (rst)
    path_done_w |-> !up_w_ready);
  no_ar_when_iso_a: assert property (@(posedge clk) disable iff (rst)
    path_done_r |-> !up_ar_ready);

endmodule

/* src/iso_path_fsm.sv */
// Isolation sequencer for one path; isolate_req must stay high until path_done is reached
`timescale 1ns/1ps

module iso_path_fsm (
  input  logic clk,
  input  logic rst,
  input  logic isolate_req,
  input  logic align_done,
  input  logic drain_done,
  output logic align_req,
  output logic drain_req,
  output logic path_done
);

  import axi_iso_pkg::*;

  iso_state_e state;
  iso_state_e state_next;

  always_comb begin
    state_next = state;
    unique case (state)
      ST_IDLE: begin
        if (isolate_req) begin
          state_next = ST_ALIGN;
        end
      end
      ST_ALIGN: begin
        if (align_done) begin
          state_next = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        if (drain_done) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // Leave only once the requester lets go
        if (!isolate_req) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Requests stay up through every later state
  assign align_req = (state != ST_IDLE);
  assign drain_req = (state == ST_DRAIN) || (state == ST_DONE);
  assign path_done = (state == ST_DONE);

  // Requester may only release after the path has finished isolating
  req_fall_legal_a: assert property (@(posedge clk) disable iff (rst)
    $fell(isolate_req) |-> path_done);

endmodule

/* src/iso_req_tracker.sv */
// Outstanding request counter for one path; responses are assumed to return one per request
`timescale 1ns/1ps
`include "axi_iso_consts.svh"

module iso_req_tracker (
  input  logic clk,
  input  logic rst,
  input  logic drain_req,
  input  logic up_ax_valid,
  output logic up_ax_ready,
  output logic dn_ax_valid,
  input  logic dn_ax_ready,
  input  logic dn_x_valid,
  output logic dn_x_ready,
  output logic up_x_valid,
  input  logic up_x_ready,
  output logic drain_done
);

  import axi_iso_pkg::*;

  outst_cnt_t outst_cnt;
  logic       req_blocked;
  logic       ax_hs;
  logic       x_hs;

  // No new requests when full or once draining has begun
  assign req_blocked = drain_req ||
                       (outst_cnt == outst_cnt_t'(`AXI_ISO_MAX_OUTSTANDING));

  assign dn_ax_valid = up_ax_valid && !req_blocked;
  assign up_ax_ready = dn_ax_ready && !req_blocked;

  // While draining, responses are taken here and hidden from upstream
  assign dn_x_ready = drain_req || up_x_ready;
  assign up_x_valid = dn_x_valid && !drain_req;

  assign ax_hs = dn_ax_valid && dn_ax_ready;
  assign x_hs  = dn_x_valid && dn_x_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      outst_cnt <= '0;
    end else begin
      case ({ax_hs, x_hs})
        2'b10: begin
          outst_cnt <= outst_cnt + outst_cnt_t'(1);
        end
        2'b01: begin
          outst_cnt <= outst_cnt - outst_cnt_t'(1);
        end
        default: begin
          outst_cnt <= outst_cnt;
        end
      endcase
    end
  end

  // Nothing left in flight, so the path is quiet
  assign drain_done = drain_req && (outst_cnt == '0);

  // Subordinate must not answer a request that was never sent
  no_underflow_a: assert property (@(posedge clk) disable iff (rst)
    x_hs |-> (outst_cnt != '0));

endmodule

/* src/iso_wdata_align.sv */
// AW/W skew tracking for AXI-Lite single beats; W may never lead AW, fake beats fill the gap
`timescale 1ns/1ps
`include "axi_iso_consts.svh"

module iso_wdata_align (
  input  logic clk,
  input  logic rst,
  input  logic align_req,
  input  logic up_aw_valid,
  output logic up_aw_ready,
  input  logic up_w_valid,
  output logic up_w_ready,
  output logic dn_aw_valid,
  input  logic dn_aw_ready,
  output logic dn_w_valid,
  input  logic dn_w_ready,
  output logic align_done
);

  import axi_iso_pkg::*;

  skew_cnt_t skew_cnt;
  logic      aw_blocked;
  logic      w_allowed;
  logic      aw_hs;
  logic      w_hs;

  // Upstream AW stops at the skew limit and for the whole isolation
  assign aw_blocked  = align_req || (skew_cnt == skew_cnt_t'(`AXI_ISO_MAX_SKEW));
  assign dn_aw_valid = up_aw_valid && !aw_blocked;
  assign up_aw_ready = dn_aw_ready && !aw_blocked;
  assign aw_hs       = dn_aw_valid && dn_aw_ready;

  // A data beat needs an address that is already through or passing now
  assign w_allowed = (skew_cnt != '0) || aw_hs;

  always_comb begin
    if (align_req) begin
      // Upstream W is cut off; fake beats repay the skew
      up_w_ready = 1'b0;
      dn_w_valid = (skew_cnt != '0);
    end else begin
      up_w_ready = dn_w_ready && w_allowed;
      dn_w_valid = up_w_valid && w_allowed;
    end
  end

  assign w_hs = dn_w_valid && dn_w_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      skew_cnt <= '0;
    end else begin
      case ({aw_hs, w_hs})
        2'b10: begin
          skew_cnt <= skew_cnt + skew_cnt_t'(1);
        end
        2'b01: begin
          skew_cnt <= skew_cnt - skew_cnt_t'(1);
        end
        default: begin
          skew_cnt <= skew_cnt;
        end
      endcase
    end
  end

  assign align_done = align_req && (skew_cnt == '0);

endmodule

/* tests/tb_axi_isolate.sv */
// Random-traffic testbench for the AXI-Lite isolator; the subordinate model takes W only after its AW
`timescale 1ns/1ps
`include "axi_iso_consts.svh"

module tb_axi_isolate;

  import axi_iso_pkg::*;

  // Five tests of up to 600 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic    clk = 1'b0;
  logic    rst;
  logic    isolate_req;
  logic    isolate_done;
  aw_req_t up_aw = '0;
  logic    up_aw_valid = 1'b0;
  logic    up_aw_ready;
  w_beat_t up_w = '0;
  logic    up_w_valid = 1'b0;
  logic    up_w_ready;
  b_rsp_t  up_b;
  logic    up_b_valid;
  logic    up_b_ready = 1'b0;
  ar_req_t up_ar = '0;
  logic    up_ar_valid = 1'b0;
  logic    up_ar_ready;
  r_rsp_t  up_r;
  logic    up_r_valid;
  logic    up_r_ready = 1'b0;
  aw_req_t dn_aw;
  logic    dn_aw_valid;
  logic    dn_aw_ready = 1'b0;
  w_beat_t dn_w;
  logic    dn_w_valid;
  logic    dn_w_ready = 1'b0;
  b_rsp_t  dn_b = '0;
  logic    dn_b_valid = 1'b0;
  logic    dn_b_ready;
  ar_req_t dn_ar;
  logic    dn_ar_valid;
  logic    dn_ar_ready = 1'b0;
  r_rsp_t  dn_r = '0;
  logic    dn_r_valid = 1'b0;
  logic    dn_r_ready;

  integer  seed = 32'hf2cb_f2e4;
  logic    traffic_en;
  logic    skew_mode;
  logic    bp_heavy;
  logic    mgr_reset;
  int      mgr_aw_sent;
  int      mgr_w_sent;
  int      aw_cnt;
  int      w_cnt;
  int      b_cnt;
  int      ar_cnt;
  int      r_cnt;
  int      err_cnt = 0;
  int      err_base = 0;
  int      test_num = 0;
  int      cycle_cnt;

  // Expected downstream order, filled from upstream handshakes
  aw_req_t aw_q[$];
  w_beat_t w_q[$];
  ar_req_t ar_q[$];
  aw_req_t aw_head;
  w_beat_t w_head;
  ar_req_t ar_head;
  int      aw_left = 0;
  int      w_left = 0;
  int      ar_left = 0;
  w_beat_t fill_beat;

  assign fill_beat = '{data: `AXI_ISO_FILL_WDATA, strb: `AXI_ISO_FILL_WSTRB};

  axi_lite_isolate_mgr DUT (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic bit chance(input int pct);
    return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  function automatic logic [63:0] rand_bits();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    err_cnt++;
    $display("[ERROR] %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
  endtask

  task automatic report_text(input string msg);
    err_cnt++;
    $display("Check failed: %s at %0t", msg, $time);
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d %s: %0d failed checks", test_num, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  task automatic isolate_and_release();
    isolate_req <= 1'b1;
    do begin
      @(posedge clk);
    end while (!isolate_done);
    // Manager is reset while it is cut off
    mgr_reset <= 1'b1;
    @(posedge clk);
    mgr_reset <= 1'b0;
    repeat (8) @(posedge clk);
    isolate_req <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  // Upstream manager and downstream subordinate models
  always @(posedge clk) begin
    logic [63:0] rnd;
    int          ready_pct;
    if (rst || mgr_reset) begin
      up_aw_valid <= 1'b0;
      up_w_valid  <= 1'b0;
      up_ar_valid <= 1'b0;
      mgr_aw_sent = 0;
      mgr_w_sent  = 0;
    end else begin
      if (up_aw_valid && up_aw_ready) begin
        mgr_aw_sent++;
      end
      if (up_w_valid && up_w_ready) begin
        mgr_w_sent++;
      end
      if (!up_aw_valid || up_aw_ready) begin
        rnd = rand_bits();
        up_aw_valid <= traffic_en && chance(40);
        up_aw       <= rnd[$bits(aw_req_t)-1:0];
      end
      // Skew mode leaves addresses without data
      if (!up_w_valid || up_w_ready) begin
        rnd = rand_bits();
        up_w_valid <= traffic_en && !skew_mode && (mgr_w_sent < mgr_aw_sent) && chance(50);
        up_w       <= rnd[$bits(w_beat_t)-1:0];
      end
      if (!up_ar_valid || up_ar_ready) begin
        rnd = rand_bits();
        up_ar_valid <= traffic_en && chance(40);
        up_ar       <= rnd[$bits(ar_req_t)-1:0];
      end
    end
    up_b_ready <= chance(70);
    up_r_ready <= chance(70);

    if (rst) begin
      dn_aw_ready <= 1'b0;
      dn_w_ready  <= 1'b0;
      dn_ar_ready <= 1'b0;
      dn_b_valid  <= 1'b0;
      dn_r_valid  <= 1'b0;
      aw_cnt = 0;
      w_cnt  = 0;
      b_cnt  = 0;
      ar_cnt = 0;
      r_cnt  = 0;
    end else begin
      aw_cnt += int'(dn_aw_valid && dn_aw_ready);
      w_cnt  += int'(dn_w_valid && dn_w_ready);
      b_cnt  += int'(dn_b_valid && dn_b_ready);
      ar_cnt += int'(dn_ar_valid && dn_ar_ready);
      r_cnt  += int'(dn_r_valid && dn_r_ready);
      ready_pct = bp_heavy ? 25 : 80;
      dn_aw_ready <= chance(ready_pct);
      dn_w_ready  <= chance(ready_pct) && (w_cnt < aw_cnt);
      dn_ar_ready <= chance(ready_pct);
      // One B per AW/W pair and one R per AR, each after a random wait
      if (!dn_b_valid || dn_b_ready) begin
        rnd = rand_bits();
        dn_b_valid <= (w_cnt > b_cnt) && chance(30);
        dn_b       <= rnd[$bits(b_rsp_t)-1:0];
      end
      if (!dn_r_valid || dn_r_ready) begin
        rnd = rand_bits();
        dn_r_valid <= (ar_cnt > r_cnt) && chance(30);
        dn_r       <= rnd[$bits(r_rsp_t)-1:0];
      end
    end
  end

  // Pop before push, since a request needs a cycle to cross
  always @(posedge clk) begin
    if (dn_aw_valid && dn_aw_ready && aw_q.size() != 0) void'(aw_q.pop_front());
    if (dn_w_valid && dn_w_ready && w_q.size() != 0) void'(w_q.pop_front());
    if (dn_ar_valid && dn_ar_ready && ar_q.size() != 0) void'(ar_q.pop_front());
    if (up_aw_valid && up_aw_ready) aw_q.push_back(up_aw);
    if (up_w_valid && up_w_ready) w_q.push_back(up_w);
    if (up_ar_valid && up_ar_ready) ar_q.push_back(up_ar);
    aw_head <= (aw_q.size() != 0) ? aw_q[0] : '0;
    w_head  <= (w_q.size() != 0) ? w_q[0] : fill_beat;
    ar_head <= (ar_q.size() != 0) ? ar_q[0] : '0;
    aw_left <= aw_q.size();
    w_left  <= w_q.size();
    ar_left <= ar_q.size();
  end

  aw_order_a: assert property (@(posedge clk) disable iff (rst)
    dn_aw_valid && dn_aw_ready |-> aw_left != 0 && dn_aw == aw_head)
    else report_value("dn_aw", 64'($sampled(aw_head)), 64'($sampled(dn_aw)));
  // With no real beat queued only a fill beat during isolation is legal
  w_order_a: assert property (@(posedge clk) disable iff (rst)
    dn_w_valid && dn_w_ready |-> (w_left != 0 || isolate_req) && dn_w == w_head)
    else report_value("dn_w", 64'($sampled(w_head)), 64'($sampled(dn_w)));
  ar_order_a: assert property (@(posedge clk) disable iff (rst)
    dn_ar_valid && dn_ar_ready |-> ar_left != 0 && dn_ar == ar_head)
    else report_value("dn_ar", 64'($sampled(ar_head)), 64'($sampled(dn_ar)));

  b_pass_a: assert property (@(posedge clk) disable iff (rst)
    !isolate_req && !isolate_done |-> up_b_valid == dn_b_valid && up_b == dn_b)
    else report_value("up_b", 64'({$sampled(dn_b_valid), $sampled(dn_b)}),
                      64'({$sampled(up_b_valid), $sampled(up_b)}));
  r_pass_a: assert property (@(posedge clk) disable iff (rst)
    !isolate_req && !isolate_done |-> up_r_valid == dn_r_valid && up_r == dn_r)
    else report_value("up_r", 64'({$sampled(dn_r_valid), $sampled(dn_r)}),
                      64'({$sampled(up_r_valid), $sampled(up_r)}));

  wr_limit_a: assert property (@(posedge clk) disable iff (rst)
    aw_cnt - b_cnt <= `AXI_ISO_MAX_OUTSTANDING)
    else report_text("too many write requests outstanding downstream");
  rd_limit_a: assert property (@(posedge clk) disable iff (rst)
    ar_cnt - r_cnt <= `AXI_ISO_MAX_OUTSTANDING)
    else report_text("too many read requests outstanding downstream");
  w_lag_a: assert property (@(posedge clk) disable iff (rst) w_cnt <= aw_cnt)
    else report_text("more write beats than write addresses downstream");

  clean_w_a: assert property (@(posedge clk) disable iff (rst)
    $rose(isolate_done) |-> w_cnt == aw_cnt)
    else report_value("dn_w count", 64'($sampled(aw_cnt)), 64'($sampled(w_cnt)));
  clean_b_a: assert property (@(posedge clk) disable iff (rst)
    $rose(isolate_done) |-> b_cnt == aw_cnt)
    else report_value("dn_b count", 64'($sampled(aw_cnt)), 64'($sampled(b_cnt)));
  clean_r_a: assert property (@(posedge clk) disable iff (rst)
    $rose(isolate_done) |-> r_cnt == ar_cnt)
    else report_value("dn_r count", 64'($sampled(ar_cnt)), 64'($sampled(r_cnt)));

  blocked_a: assert property (@(posedge clk) disable iff (rst)
    isolate_req && isolate_done |->
      !(up_aw_ready || up_w_ready || up_ar_ready || up_b_valid || up_r_valid))
    else report_value("up_aw_ready,up_w_ready,up_ar_ready,up_b_valid,up_r_valid", 64'h0,
                      64'($sampled({up_aw_ready, up_w_ready, up_ar_ready,
                                    up_b_valid, up_r_valid})));

  release_a: assert property (@(posedge clk) disable iff (rst)
    $fell(isolate_done) == ($past(isolate_req, 3) && !$past(isolate_req, 2)))
    else report_text("isolate_done did not fall two cycles after isolate_req fell");

  initial begin
    rst         <= 1'b1;
    isolate_req <= 1'b0;
    traffic_en  <= 1'b0;
    skew_mode   <= 1'b0;
    bp_heavy    <= 1'b0;
    mgr_reset   <= 1'b0;
    repeat (16) @(posedge clk);
    rst        <= 1'b0;
    traffic_en <= 1'b1;
    repeat (300) @(posedge clk);
    end_test("forward");
    repeat (80) @(posedge clk);
    isolate_and_release();
    end_test("isolate_busy");
    repeat (200) @(posedge clk);
    end_test("release_forward");
    skew_mode <= 1'b1;
    repeat (60) @(posedge clk);
    isolate_and_release();
    skew_mode <= 1'b0;
    end_test("isolate_skew");
    bp_heavy <= 1'b1;
    repeat (150) @(posedge clk);
    isolate_and_release();
    traffic_en <= 1'b0;
    repeat (40) @(posedge clk);
    end_test("isolate_backpressure");
    $display("Tests run: %0d, failed checks: %0d", test_num, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule
